/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= udp_node_top.f
TB_TOP    ?= udp_node_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_STR  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/udp_node_tb.sv */
`default_nettype none

module udp_node_tb;

    localparam int TX_TIMEOUT  = 2500;  // cycles to cover two release periods
    localparam int LED_TIMEOUT = 100;
    localparam int MSG_LEN     = 7;
    localparam int ECHO_MAX    = 64;    // payload bytes kept by the node

    logic       clk_int;
    logic       rst_n_int;
    logic [3:0] phy_rxd;
    logic       phy_rx_dv;
    logic       phy_rx_er;
    logic [3:0] phy_txd;
    logic       phy_tx_en;
    logic       led_r;
    logic       led_g;
    logic       led_b;

    logic [7:0] last_good [$];  // stored bytes of the last good frame
    int         err_cnt;
    int         timeout_cnt;
    int         check_cnt;
    int         tx_frames;

    udp_node_top #(
        .TX_PERIOD_LOG2 (10)
    ) dut_i (
        .clk_int   (clk_int),
        .rst_n_int (rst_n_int),
        .phy_rxd   (phy_rxd),
        .phy_rx_dv (phy_rx_dv),
        .phy_rx_er (phy_rx_er),
        .phy_txd   (phy_txd),
        .phy_tx_en (phy_tx_en),
        .led_r     (led_r),
        .led_g     (led_g),
        .led_b     (led_b)
    );

    always #5 clk_int = ~clk_int;

    function automatic int expected_tx_len();
        return MSG_LEN + last_good.size();
    endfunction

    // message bytes first, then the echo
    function automatic logic [7:0] expected_tx_byte(input int idx);
        string msg;
        msg = "foobar\n";
        if (idx < MSG_LEN) begin
            return msg[idx];
        end
        return last_good[idx - MSG_LEN];
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic send_frame(input int n_bytes, input bit with_error);
        logic [7:0] data [$];
        logic [7:0] b;
        repeat (4) @(negedge clk_int);  // let the grant drop
        for (int i = 0; i < n_bytes; i++) begin
            b = 8'($urandom());
            data.push_back(b);
            @(negedge clk_int);
            phy_rx_dv = 1'b1;
            phy_rx_er = with_error;
            phy_rxd   = b[3:0];
            @(negedge clk_int);
            phy_rxd   = b[7:4];
        end
        @(negedge clk_int);
        phy_rx_dv = 1'b0;
        phy_rx_er = 1'b0;
        phy_rxd   = '0;
        if (!with_error) begin
            last_good.delete();
            for (int i = 0; i < n_bytes && i < ECHO_MAX; i++) begin
                last_good.push_back(data[i]);
            end
        end
    endtask

    task automatic wait_leds(input logic [2:0] exp_rgb, input string what);
        int n;
        n = 0;
        while ({led_r, led_g, led_b} != exp_rgb && n < LED_TIMEOUT) begin
            @(negedge clk_int);
            n++;
        end
        if ({led_r, led_g, led_b} != exp_rgb) begin
            timeout_cnt++;
            $display("timeout: LEDs never showed %s within %0d cycles", what, LED_TIMEOUT);
        end
    endtask

    task automatic wait_tx_frame(input string what);
        int start;
        int n;
        start = tx_frames;
        n = 0;
        while (tx_frames == start && n < TX_TIMEOUT) begin
            @(negedge clk_int);
            n++;
        end
        if (tx_frames == start) begin
            timeout_cnt++;
            $display("timeout: no transmit frame (%s) within %0d cycles", what, TX_TIMEOUT);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transmit monitor

    initial begin : tx_monitor
        int         nib_cnt;
        logic [3:0] low_nib;
        logic [7:0] got_byte;
        nib_cnt = 0;
        low_nib = '0;
        forever begin
            @(negedge clk_int);
            if (phy_tx_en) begin
                if (nib_cnt[0]) begin
                    got_byte = {phy_txd, low_nib};
                    if (nib_cnt / 2 < expected_tx_len()) begin
                        check_value($sformatf("phy_txd byte %0d", nib_cnt / 2), got_byte,
                                    expected_tx_byte(nib_cnt / 2));
                    end
                end else begin
                    low_nib = phy_txd;  // low nibble first
                end
                nib_cnt++;
            end else if (nib_cnt != 0) begin
                check_value("phy_tx_en nibble count", nib_cnt, 2 * expected_tx_len());
                nib_cnt = 0;
                tx_frames++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus

    initial begin : stimulus
        clk_int     = 1'b0;
        rst_n_int   = 1'b0;
        phy_rxd     = '0;
        phy_rx_dv   = 1'b0;
        phy_rx_er   = 1'b0;
        err_cnt     = 0;
        timeout_cnt = 0;
        check_cnt   = 0;
        tx_frames   = 0;
        void'($urandom(32'ha59503bb));
        repeat (10) @(negedge clk_int);
        rst_n_int = 1'b1;
        @(negedge clk_int);
        check_value("led_r", led_r, 0);
        check_value("led_g", led_g, 0);
        check_value("led_b", led_b, 0);
        check_value("phy_tx_en", phy_tx_en, 0);

        wait_tx_frame("message only");  // nothing received yet
        send_frame(5, 1'b0);
        wait_leds(3'b100, "red");
        send_frame(15, 1'b0);
        wait_leds(3'b010, "green");
        send_frame(30, 1'b0);
        wait_leds(3'b001, "blue");
        send_frame(8, 1'b1);
        repeat (8) @(negedge clk_int);  // size write lands one cycle after dv falls
        check_value("{led_r,led_g,led_b}", {led_r, led_g, led_b}, 3'b001);

        wait_tx_frame("echo of 30 bytes");
        send_frame(12, 1'b0);
        wait_leds(3'b010, "green");
        wait_tx_frame("echo of 12 bytes");
        send_frame(70, 1'b0);
        wait_leds(3'b001, "blue");
        wait_tx_frame("echo of first 64 bytes");

        repeat (4) @(negedge clk_int);
        $display("checks: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0 && check_cnt > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* udp_node_top.f */
verilog/udp_node_pkg.sv
verilog/payload_ram.sv
verilog/mii_rx_engine.sv
verilog/mii_tx_engine.sv
verilog/host_stub.sv
verilog/udp_node_top.sv
dv/udp_node_tb.sv

/* verilog/host_stub.sv */
`default_nettype none

module host_stub
    import udp_node_pkg::*;
#(
    parameter int TX_PERIOD_LOG2 = 27
)
(
    input  wire                      clk_int,
    input  wire                      rst_n_int,
    input  wire rxbuf_wr_t           rxbuf_wr,
    input  wire                      rxbuf_grant,
    output logic                     rxbuf_rel,
    input  wire [TXBUF_AWIDTH-1:0]   txbuf_addr,
    output logic [31:0]              txbuf_rdata,
    output logic                     txbuf_rel,
    output logic                     led_r,
    output logic                     led_g,
    output logic                     led_b
);

    logic [15:0]             last_rx_size;
    logic [TX_PERIOD_LOG2:0] tx_cnt;

    assign led_r = (last_rx_size >= 16'd1) && (last_rx_size <= 16'd10);
    assign led_g = (last_rx_size >= 16'd11) && (last_rx_size <= 16'd20);
    assign led_b = (last_rx_size > 16'd20);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive side, release right after grant

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            rxbuf_rel    <= 1'b0;
            last_rx_size <= '0;
        end else begin
            rxbuf_rel <= rxbuf_grant;
            if (rxbuf_wr.we && (rxbuf_wr.addr == RXBUF_AWIDTH'(RXBUF_SIZE_ADDR))) begin
                last_rx_size <= rxbuf_wr.wdata[31:16];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transmit side, periodic release and message rom

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            txbuf_rel <= 1'b0;
            tx_cnt    <= '0;
        end else if (tx_cnt[TX_PERIOD_LOG2]) begin
            txbuf_rel <= 1'b1;
            tx_cnt    <= '0;
        end else begin
            txbuf_rel <= 1'b0;
            tx_cnt    <= tx_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_int) begin
        case (txbuf_addr)
            TXBUF_AWIDTH'(TXBUF_LEN_ADDR):      txbuf_rdata <= 32'h0000_0007;
            TXBUF_AWIDTH'(TXBUF_DATA_ADDR):     txbuf_rdata <= 32'h626f_6f66;  // "foob"
            TXBUF_AWIDTH'(TXBUF_DATA_ADDR + 1): txbuf_rdata <= 32'h000a_7261;  // "ar\n"
            default:                            txbuf_rdata <= 32'h0000_0000;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mii_rx_engine.sv */
`default_nettype none

module mii_rx_engine
    import udp_node_pkg::*;
(
    input  wire          clk_int,
    input  wire          rst_n_int,
    input  wire [3:0]    phy_rxd,
    input  wire          phy_rx_dv,
    input  wire          phy_rx_er,
    input  wire          phy_tx_en,
    input  wire          rxbuf_rel,
    output rxbuf_wr_t    rxbuf_wr,
    output logic         rxbuf_grant,
    output payload_wr_t  payload_wr,
    output rx_done_t     rx_done,
    output logic         rx_busy
);

    logic        dv_q;
    logic        nib_hi;    // next nibble is the high half
    logic [3:0]  low_nib;
    logic [15:0] byte_cnt;
    logic        err_seen;
    logic        ignore;    // frame started while busy
    logic        good_end;

    assign good_end = dv_q && !phy_rx_dv && !err_seen && !ignore;
    assign rx_busy  = phy_rx_dv | dv_q | rxbuf_grant;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // nibble pairing and byte count

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            dv_q       <= 1'b0;
            nib_hi     <= 1'b0;
            low_nib    <= '0;
            byte_cnt   <= '0;
            err_seen   <= 1'b0;
            ignore     <= 1'b0;
            payload_wr <= '0;
        end else begin
            dv_q          <= phy_rx_dv;
            payload_wr.we <= 1'b0;
            if (phy_rx_dv && !dv_q) begin  // first nibble of a frame
                low_nib  <= phy_rxd;
                nib_hi   <= 1'b1;
                byte_cnt <= '0;
                err_seen <= phy_rx_er;
                ignore   <= rxbuf_grant | phy_tx_en;
            end else if (phy_rx_dv) begin
                err_seen <= err_seen | phy_rx_er;
                nib_hi   <= !nib_hi;
                if (nib_hi) begin
                    payload_wr.we   <= !ignore && !err_seen && !phy_rx_er &&
                                       (byte_cnt < 16'(PAYLOAD_DEPTH));
                    payload_wr.addr <= byte_cnt[PAYLOAD_AWIDTH-1:0];
                    payload_wr.data <= {phy_rxd, low_nib};
                    byte_cnt        <= byte_cnt + 16'd1;  // keeps counting past depth
                end else begin
                    low_nib <= phy_rxd;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame report and buffer grant

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            rxbuf_wr    <= '0;
            rx_done     <= '0;
            rxbuf_grant <= 1'b0;
        end else begin
            rxbuf_wr.we   <= good_end;
            rx_done.valid <= good_end;
            if (good_end) begin
                rxbuf_wr.addr  <= RXBUF_AWIDTH'(RXBUF_SIZE_ADDR);
                rxbuf_wr.wdata <= {byte_cnt, 16'h0000};
                rx_done.len    <= byte_cnt;
                rxbuf_grant    <= 1'b1;
            end else if (rxbuf_rel) begin
                rxbuf_grant <= 1'b0;  // host is done with it
            end
        end
    end

    a_no_wr_while_granted: assert property (
        @(posedge clk_int) disable iff (!rst_n_int)
        rxbuf_wr.we |-> !$past(rxbuf_grant)
    );

endmodule

`default_nettype wire

/* verilog/mii_tx_engine.sv */
`default_nettype none

module mii_tx_engine
    import udp_node_pkg::*;
(
    input  wire                        clk_int,
    input  wire                        rst_n_int,
    input  wire                        txbuf_rel,
    input  wire                        rx_busy,
    input  wire rx_done_t              rx_done,
    output logic [TXBUF_AWIDTH-1:0]    txbuf_addr,
    input  wire [31:0]                 txbuf_rdata,
    output logic [PAYLOAD_AWIDTH-1:0]  payload_rd_addr,
    input  wire [7:0]                  payload_rd_data,
    output logic [3:0]                 phy_txd,
    output logic                       phy_tx_en
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LEN,         // address the length word
        ST_LEN_WAIT,
        ST_PRIME_ADDR,  // address byte 0
        ST_PRIME,
        ST_SEND
    } tx_state_t;

    tx_state_t   state;
    logic [15:0] last_len;
    logic [15:0] echo_len;
    logic [15:0] msg_len;
    logic [15:0] fetch_idx;  // byte being addressed, one ahead of cur_byte
    logic [15:0] tot_len;
    logic [7:0]  cur_byte;
    logic [7:0]  next_byte;
    logic        nib_hi;

    assign tot_len   = msg_len + echo_len;
    assign next_byte = (fetch_idx < msg_len) ? txbuf_rdata[{fetch_idx[1:0], 3'b000} +: 8]
                                             : payload_rd_data;

    assign txbuf_addr = (state == ST_LEN) ? TXBUF_AWIDTH'(TXBUF_LEN_ADDR)
                      : TXBUF_AWIDTH'(TXBUF_DATA_ADDR) + fetch_idx[TXBUF_AWIDTH+1:2];
    assign payload_rd_addr = PAYLOAD_AWIDTH'(fetch_idx - msg_len);

    assign phy_txd   = nib_hi ? cur_byte[7:4] : cur_byte[3:0];  // low nibble first
    assign phy_tx_en = (state == ST_SEND);

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            state     <= ST_IDLE;
            last_len  <= '0;
            echo_len  <= '0;
            msg_len   <= '0;
            fetch_idx <= '0;
            cur_byte  <= '0;
            nib_hi    <= 1'b0;
        end else begin
            if (rx_done.valid) begin
                last_len <= rx_done.len;
            end
            case (state)
                ST_IDLE: begin
                    if (txbuf_rel && !rx_busy) begin  // pulse dropped while rx busy
                        echo_len <= (last_len > 16'(PAYLOAD_DEPTH)) ? 16'(PAYLOAD_DEPTH)
                                                                    : last_len;
                        state    <= ST_LEN;
                    end
                end
                ST_LEN: state <= ST_LEN_WAIT;
                ST_LEN_WAIT: begin
                    msg_len   <= txbuf_rdata[15:0];
                    fetch_idx <= '0;
                    state     <= ST_PRIME_ADDR;
                end
                ST_PRIME_ADDR: state <= ST_PRIME;
                ST_PRIME: begin
                    cur_byte  <= next_byte;
                    fetch_idx <= fetch_idx + 16'd1;
                    nib_hi    <= 1'b0;
                    state     <= (tot_len == '0) ? ST_IDLE : ST_SEND;
                end
                ST_SEND: begin
                    nib_hi <= !nib_hi;
                    if (nib_hi) begin
                        cur_byte  <= next_byte;
                        fetch_idx <= fetch_idx + 16'd1;
                        if (fetch_idx == tot_len) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_tx_start_rx_idle: assert property (
        @(posedge clk_int) disable iff (!rst_n_int)
        $rose(phy_tx_en) |-> !rx_busy
    );

endmodule

`default_nettype wire

/* verilog/payload_ram.sv */
`default_nettype none

module payload_ram
    import udp_node_pkg::*;
(
    input  wire                       clk_int,
    input  wire payload_wr_t          wr,
    input  wire [PAYLOAD_AWIDTH-1:0]  rd_addr,
    output logic [7:0]                rd_data
);

    logic [7:0] mem [PAYLOAD_DEPTH];

    always_ff @(posedge clk_int) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
        rd_data <= mem[rd_addr];  // read-before-write on a collision
    end

endmodule

`default_nettype wire

/* verilog/udp_node_pkg.sv */
`default_nettype none

package udp_node_pkg;

    localparam int RXBUF_AWIDTH    = 6;
    localparam int TXBUF_AWIDTH    = 6;
    localparam int PAYLOAD_DEPTH   = 64;
    localparam int PAYLOAD_AWIDTH  = 6;
    localparam int RXBUF_SIZE_ADDR = 1;  // size in bits 31..16
    localparam int TXBUF_LEN_ADDR  = 2;
    localparam int TXBUF_DATA_ADDR = 3;  // message starts here, lsb first

    // udp receive-buffer write port
    typedef struct packed {
        logic [RXBUF_AWIDTH-1:0] addr;
        logic                    we;
        logic [31:0]             wdata;
    } rxbuf_wr_t;

    typedef struct packed {
        logic                      we;
        logic [PAYLOAD_AWIDTH-1:0] addr;
        logic [7:0]                data;
    } payload_wr_t;

    // good frame finished, len in bytes
    typedef struct packed {
        logic        valid;
        logic [15:0] len;
    } rx_done_t;

endpackage

`default_nettype wire

/* verilog/udp_node_top.sv */
`default_nettype none

module udp_node_top
    import udp_node_pkg::*;
#(
    parameter int TX_PERIOD_LOG2 = 27
)
(
    input  wire        clk_int,
    input  wire        rst_n_int,
    input  wire [3:0]  phy_rxd,
    input  wire        phy_rx_dv,
    input  wire        phy_rx_er,
    output wire [3:0]  phy_txd,
    output wire        phy_tx_en,
    output wire        led_r,
    output wire        led_g,
    output wire        led_b
);

    wire rxbuf_wr_t               rxbuf_wr;
    wire                          rxbuf_grant;
    wire                          rxbuf_rel;
    wire payload_wr_t             payload_wr;
    wire rx_done_t                rx_done;
    wire                          rx_busy;
    wire [TXBUF_AWIDTH-1:0]       txbuf_addr;
    wire [31:0]                   txbuf_rdata;
    wire                          txbuf_rel;
    wire [PAYLOAD_AWIDTH-1:0]     payload_rd_addr;
    wire [7:0]                    payload_rd_data;

    payload_ram payload_ram_i (
        .clk_int (clk_int),
        .wr      (payload_wr),
        .rd_addr (payload_rd_addr),
        .rd_data (payload_rd_data)
    );

    mii_rx_engine mii_rx_engine_i (
        .clk_int     (clk_int),
        .rst_n_int   (rst_n_int),
        .phy_rxd     (phy_rxd),
        .phy_rx_dv   (phy_rx_dv),
        .phy_rx_er   (phy_rx_er),
        .phy_tx_en   (phy_tx_en),
        .rxbuf_rel   (rxbuf_rel),
        .rxbuf_wr    (rxbuf_wr),
        .rxbuf_grant (rxbuf_grant),
        .payload_wr  (payload_wr),
        .rx_done     (rx_done),
        .rx_busy     (rx_busy)
    );

    mii_tx_engine mii_tx_engine_i (
        .clk_int         (clk_int),
        .rst_n_int       (rst_n_int),
        .txbuf_rel       (txbuf_rel),
        .rx_busy         (rx_busy),
        .rx_done         (rx_done),
        .txbuf_addr      (txbuf_addr),
        .txbuf_rdata     (txbuf_rdata),
        .payload_rd_addr (payload_rd_addr),
        .payload_rd_data (payload_rd_data),
        .phy_txd         (phy_txd),
        .phy_tx_en       (phy_tx_en)
    );

    host_stub #(
        .TX_PERIOD_LOG2 (TX_PERIOD_LOG2)
    ) host_stub_i (
        .clk_int     (clk_int),
        .rst_n_int   (rst_n_int),
        .rxbuf_wr    (rxbuf_wr),
        .rxbuf_grant (rxbuf_grant),
        .rxbuf_rel   (rxbuf_rel),
        .txbuf_addr  (txbuf_addr),
        .txbuf_rdata (txbuf_rdata),
        .txbuf_rel   (txbuf_rel),
        .led_r       (led_r),
        .led_g       (led_g),
        .led_b       (led_b)
    );

endmodule

`default_nettype wire
